/* src/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry, direct mapped
`define DC_SETS 8
`define DC_LINE_BYTES 64

// memory bus, a line moves as DC_BEATS beats of DC_BEAT_BITS
`define DC_BEAT_BITS 128
`define DC_BEATS 4

// core byte address width
`define DC_ADDR_BITS 14

`endif

/* src/dcache_pkg.sv */
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_BITS-1:0] addr_t;
    // byte address divided by the beat size in bytes
    typedef logic [`DC_ADDR_BITS-$clog2(`DC_BEAT_BITS/8)-1:0] beat_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [`DC_BEAT_BITS-1:0] beat_t;
    typedef logic [`DC_ADDR_BITS-$clog2(`DC_SETS)-$clog2(`DC_LINE_BYTES)-1:0] tag_t;
    typedef logic [$clog2(`DC_SETS)-1:0] set_idx_t;
    typedef logic [$clog2(`DC_BEATS)-1:0] beat_cnt_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [1:0] size_t;

    // access size encoding
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // field view of a byte address, msb first
    typedef struct packed {
        tag_t tag;
        set_idx_t set;
        beat_cnt_t beat;
        logic [$clog2(`DC_BEAT_BITS/32)-1:0] word;
        logic [1:0] byte_off;
    } addr_split_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        size_t size;
        logic is_unsigned;
        logic is_store;
    } core_req_t;

    typedef struct packed {
        beat_addr_t beat_addr;
        beat_t wdata;
        logic is_write;
    } mem_req_t;

    // one word access into the line array, from a hit or a finished miss
    typedef struct packed {
        logic active;
        logic is_store;
        logic is_unsigned;
        addr_t addr;
        word_t wdata;
        size_t size;
    } word_acc_t;

    typedef enum logic [1:0] {
        META_NONE,
        META_FILL,
        META_DIRTY
    } meta_kind_t;

    typedef struct packed {
        meta_kind_t kind;
        set_idx_t set;
        tag_t tag;
    } meta_upd_t;

    typedef enum logic [1:0] {
        CTRL_READY,
        CTRL_EVICT,
        CTRL_REFILL,
        CTRL_FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/dcache_tags.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_tags (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_fire,
    input  dcache_pkg::core_req_t req,
    input  dcache_pkg::meta_upd_t meta_upd,
    output dcache_pkg::core_req_t req_q,
    output logic                  req_q_valid,
    output logic                  hit,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag
);
    import dcache_pkg::*;

    logic valid [`DC_SETS];
    logic dirty [`DC_SETS];
    tag_t tags [`DC_SETS];

    addr_split_t q_addr;

    assign q_addr = req_q.addr;

    // lookup stage, one cycle after acceptance
    assign hit = req_q_valid && valid[q_addr.set] && (tags[q_addr.set] == q_addr.tag);
    assign victim_dirty = valid[q_addr.set] && dirty[q_addr.set];
    assign victim_tag = tags[q_addr.set];

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q_valid <= 1'b0;
            for (int s = 0; s < `DC_SETS; s++) begin
                valid[s] <= 1'b0;
                dirty[s] <= 1'b0;
            end
        end else begin
            req_q_valid <= req_fire;
            case (meta_upd.kind)
                META_FILL: begin
                    // refilled line comes in clean
                    valid[meta_upd.set] <= 1'b1;
                    dirty[meta_upd.set] <= 1'b0;
                    tags[meta_upd.set] <= meta_upd.tag;
                end
                META_DIRTY: begin
                    dirty[meta_upd.set] <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // the core only sends naturally aligned accesses
    a_req_aligned: assert property (@(posedge clk) disable iff (rst)
        req_fire |-> ((req.size == SIZE_BYTE) ||
                      ((req.size == SIZE_HALF) && !req.addr[0]) ||
                      ((req.size == SIZE_WORD) && (req.addr[1:0] == 2'b00))))
        else $error("unaligned core request at %h", req.addr);

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::core_req_t req_q,
    input  logic                  req_q_valid,
    input  logic                  hit,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::beat_t     victim_beat,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output logic                  mem_req_valid,
    output logic                  fill_we,
    output dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::beat_cnt_t fill_beat,
    output dcache_pkg::set_idx_t  fill_set,
    output dcache_pkg::word_acc_t acc,
    output dcache_pkg::meta_upd_t meta_upd
);
    import dcache_pkg::*;

    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(`DC_BEATS - 1);

    ctrl_state_t state;
    ctrl_state_t state_nx;
    logic out_of_reset;
    core_req_t held;
    core_req_t src;
    addr_split_t held_a;
    addr_split_t src_a;
    beat_cnt_t req_cnt;
    beat_cnt_t rsp_cnt;
    logic rd_done;
    logic lookup_hit;
    logic miss;
    logic mem_fire;
    logic last_rsp;

    assign lookup_hit = (state == CTRL_READY) && req_q_valid && hit;
    assign miss = (state == CTRL_READY) && req_q_valid && !hit;
    assign mem_fire = mem_req_valid && mem_req_ready;
    assign last_rsp = fill_we && (rsp_cnt == LAST_BEAT);

    // new requests wait while a miss is found or handled
    assign req_ready = out_of_reset && (state == CTRL_READY) && !miss;

    always_comb begin
        state_nx = state;
        case (state)
            CTRL_READY: begin
                if (miss) begin
                    state_nx = victim_dirty ? CTRL_EVICT : CTRL_REFILL;
                end
            end
            CTRL_EVICT: begin
                if (mem_fire && (req_cnt == LAST_BEAT)) begin
                    state_nx = CTRL_REFILL;
                end
            end
            CTRL_REFILL: begin
                if (last_rsp) begin
                    state_nx = CTRL_FINISH;
                end
            end
            default: begin
                state_nx = CTRL_READY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTRL_READY;
            out_of_reset <= 1'b0;
            req_cnt <= '0;
            rsp_cnt <= '0;
            rd_done <= 1'b0;
        end else begin
            state <= state_nx;
            out_of_reset <= 1'b1;
            // one counter serves the write beats and then the read beats
            if (mem_fire) begin
                req_cnt <= req_cnt + 1'b1;
                if ((state == CTRL_REFILL) && (req_cnt == LAST_BEAT)) begin
                    rd_done <= 1'b1;
                end
            end
            if (fill_we) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            if (state == CTRL_FINISH) begin
                rd_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            held <= req_q;
        end
    end

    assign held_a = held.addr;
    assign src = (state == CTRL_READY) ? req_q : held;
    assign src_a = src.addr;

    // victim beats go to the old tag, read beats to the missed one
    assign mem_req_valid = (state == CTRL_EVICT) || ((state == CTRL_REFILL) && !rd_done);
    assign mem_req.is_write = (state == CTRL_EVICT);
    assign mem_req.beat_addr = {mem_req.is_write ? victim_tag : held_a.tag,
                                held_a.set, req_cnt};
    assign mem_req.wdata = mem_req.is_write ? victim_beat : '0;

    assign fill_we = (state == CTRL_REFILL) && mem_rsp_valid;
    assign fill_beat = rsp_cnt;
    assign fill_set = held_a.set;

    always_comb begin
        acc.active = lookup_hit || (state == CTRL_FINISH);
        acc.is_store = src.is_store;
        acc.is_unsigned = src.is_unsigned;
        acc.addr = src.addr;
        acc.wdata = src.wdata;
        acc.size = src.size;
    end

    assign rsp_valid = acc.active && !acc.is_store;

    always_comb begin
        meta_upd.set = src_a.set;
        meta_upd.tag = src_a.tag;
        if (last_rsp) begin
            meta_upd.kind = META_FILL;
        end else if (acc.active && acc.is_store) begin
            meta_upd.kind = META_DIRTY;
        end else begin
            meta_upd.kind = META_NONE;
        end
    end

    a_rsp_in_refill: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> (state == CTRL_REFILL))
        else $error("memory response outside refill");

    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else $error("memory request changed while stalled");

endmodule

`default_nettype wire

/* src/dcache_lines.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_lines (
    input  logic                  clk,
    input  dcache_pkg::word_acc_t acc,
    input  logic                  fill_we,
    input  dcache_pkg::set_idx_t  fill_set,
    input  dcache_pkg::beat_cnt_t fill_beat,
    input  dcache_pkg::beat_t     fill_data,
    input  dcache_pkg::beat_cnt_t evict_beat,
    output dcache_pkg::word_t     rd_word,
    output dcache_pkg::beat_t     victim_beat
);
    import dcache_pkg::*;

    beat_t data [`DC_SETS][`DC_BEATS];

    addr_split_t a;
    byte_mask_t mask;
    word_t wdata_sh;

    assign a = acc.addr;

    always_comb begin
        case (acc.size)
            SIZE_BYTE: mask = byte_mask_t'(4'b0001 << a.byte_off);
            SIZE_HALF: mask = byte_mask_t'(4'b0011 << a.byte_off);
            default: mask = 4'b1111;
        endcase
    end

    // store data arrives lsb aligned, move it to its byte lane
    assign wdata_sh = acc.wdata << {a.byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data[fill_set][fill_beat] <= fill_data;
        end
        if (acc.active && acc.is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    data[a.set][a.beat][$bits(word_t)*a.word + 8*b +: 8] <= wdata_sh[8*b +: 8];
                end
            end
        end
    end

    assign rd_word = data[a.set][a.beat][$bits(word_t)*a.word +: $bits(word_t)];
    assign victim_beat = data[fill_set][evict_beat];

endmodule

`default_nettype wire

/* src/dcache_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_load_align (
    input  dcache_pkg::word_acc_t acc,
    input  dcache_pkg::word_t     rd_word,
    output dcache_pkg::word_t     rsp_data
);
    import dcache_pkg::*;

    addr_split_t a;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic sext;

    assign a = acc.addr;
    assign byte_sel = rd_word[8*a.byte_off +: 8];
    // halves sit on even bytes only
    assign half_sel = rd_word[16*a.byte_off[1] +: 16];
    assign sext = !acc.is_unsigned;

    always_comb begin
        case (acc.size)
            SIZE_BYTE: rsp_data = {{24{sext & byte_sel[7]}}, byte_sel};
            SIZE_HALF: rsp_data = {{16{sext & half_sel[15]}}, half_sel};
            default: rsp_data = rd_word;
        endcase
    end

endmodule

`default_nettype wire

/* src/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  dcache_pkg::core_req_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output dcache_pkg::word_t    rsp_data,
    output logic                 mem_req_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  dcache_pkg::beat_t    mem_rsp_data
);
    import dcache_pkg::*;

    logic req_fire;
    core_req_t req_q;
    logic req_q_valid;
    logic hit;
    logic victim_dirty;
    tag_t victim_tag;
    beat_t victim_beat;
    meta_upd_t meta_upd;
    word_acc_t acc;
    word_t rd_word;
    logic fill_we;
    beat_cnt_t fill_beat;
    set_idx_t fill_set;
    beat_cnt_t evict_beat;

    assign req_fire = req_valid && req_ready;
    // the beat in flight is the low part of the outgoing beat address
    assign evict_beat = mem_req.beat_addr[$bits(beat_cnt_t)-1:0];

    dcache_tags i_dcache_tags (
        .clk          (clk),
        .rst          (rst),
        .req_fire     (req_fire),
        .req          (req),
        .meta_upd     (meta_upd),
        .req_q        (req_q),
        .req_q_valid  (req_q_valid),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_q         (req_q),
        .req_q_valid   (req_q_valid),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .victim_beat   (victim_beat),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .mem_req_valid (mem_req_valid),
        .fill_we       (fill_we),
        .mem_req       (mem_req),
        .fill_beat     (fill_beat),
        .fill_set      (fill_set),
        .acc           (acc),
        .meta_upd      (meta_upd)
    );

    dcache_lines i_dcache_lines (
        .clk         (clk),
        .acc         (acc),
        .fill_we     (fill_we),
        .fill_set    (fill_set),
        .fill_beat   (fill_beat),
        .fill_data   (mem_rsp_data),
        .evict_beat  (evict_beat),
        .rd_word     (rd_word),
        .victim_beat (victim_beat)
    );

    dcache_load_align i_dcache_load_align (
        .acc      (acc),
        .rd_word  (rd_word),
        .rsp_data (rsp_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req_valid,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_req_ready,
    output logic                 mem_rsp_valid,
    output dcache_pkg::beat_t    mem_rsp_data
);
    import dcache_pkg::*;

    localparam int BEATS = 1 << $bits(beat_addr_t);

    beat_t mem [BEATS];
    beat_addr_t pending [$];
    // logs of accepted beats, read back by the testbench
    beat_addr_t rd_addrs [$];
    beat_addr_t wr_addrs [$];
    beat_t wr_data [$];
    int rd_count = 0;
    int wr_count = 0;

    // same byte pattern as the testbench reference
    function automatic logic [7:0] pattern_byte(addr_t a);
        return a[7:0] ^ 8'(a >> 8);
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        for (int k = 0; k < BEATS; k++) begin
            for (int b = 0; b < $bits(beat_t) / 8; b++) begin
                mem[beat_addr_t'(k)][8*b +: 8] = pattern_byte(addr_t'(k * 16 + b));
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready) begin
            if (mem_req.is_write) begin
                mem[mem_req.beat_addr] = mem_req.wdata;
                wr_addrs.push_back(mem_req.beat_addr);
                wr_data.push_back(mem_req.wdata);
                wr_count++;
            end else begin
                pending.push_back(mem_req.beat_addr);
                rd_addrs.push_back(mem_req.beat_addr);
                rd_count++;
            end
        end
        #1;
        // roughly one stall in four on both ready and read data
        mem_req_ready = ($urandom % 4) != 0;
        if (!rst && (pending.size() > 0) && (($urandom % 4) != 0)) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data = mem[pending.pop_front()];
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;
    import dcache_pkg::*;

    // five misses and about thirty-five hits fit well inside this
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int MEM_BYTES = 1 << $bits(addr_t);
    localparam int LINE_OFF_BITS = $bits(addr_t) - $bits(tag_t) - $bits(set_idx_t);

    logic clk;
    logic rst;
    logic req_valid;
    core_req_t req;
    logic req_ready;
    logic rsp_valid;
    word_t rsp_data;
    logic mem_req_valid;
    mem_req_t mem_req;
    logic mem_req_ready;
    logic mem_rsp_valid;
    beat_t mem_rsp_data;

    // byte view of memory as the core should see it
    logic [7:0] ref_mem [MEM_BYTES];
    int cycles = 0;

    dcache_top i_dcache_top (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    tb_mem_model i_mem_model (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
            stop_run();
        end
    endtask

    task automatic check_val(string name, beat_t expected, beat_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %0h got %0h at %0t", name, expected, actual, $time);
            stop_run();
        end
    endtask

    function automatic logic [7:0] pattern_byte(addr_t a);
        return a[7:0] ^ 8'(a >> 8);
    endfunction

    function automatic addr_t line_addr(int tag, int set, int offset);
        return {tag_t'(tag), set_idx_t'(set), LINE_OFF_BITS'(offset)};
    endfunction

    function automatic beat_addr_t line_beat(addr_t a, int i);
        return {a[$bits(addr_t)-1:LINE_OFF_BITS], beat_cnt_t'(i)};
    endfunction

    // size picks 1, 2 or 4 bytes, signed loads extend the top bit
    function automatic word_t expect_load(addr_t a, size_t size, logic is_unsigned);
        word_t raw;
        int nbytes;
        nbytes = 1 << size;
        raw = '0;
        for (int i = 0; i < nbytes; i++) begin
            raw[8*i +: 8] = ref_mem[a + addr_t'(i)];
        end
        if (!is_unsigned && (nbytes < 4) && raw[8*nbytes-1]) begin
            raw = raw | (32'hffff_ffff << (8 * nbytes));
        end
        return raw;
    endfunction

    function automatic beat_t model_beat(beat_addr_t ba);
        beat_t b;
        addr_t a0;
        a0 = {ba, 4'b0000};
        for (int i = 0; i < $bits(beat_t) / 8; i++) begin
            b[8*i +: 8] = ref_mem[a0 + addr_t'(i)];
        end
        return b;
    endfunction

    task automatic model_store(addr_t a, size_t size, word_t wdata);
        for (int i = 0; i < (1 << size); i++) begin
            ref_mem[a + addr_t'(i)] = wdata[8*i +: 8];
        end
    endtask

    // the write beats since wbase must be the whole line of a, as the model holds it
    task automatic check_writeback(addr_t a, int wbase);
        check_val("mem write beats", beat_t'(4), beat_t'(i_mem_model.wr_count - wbase));
        for (int i = 0; i < 4; i++) begin
            check_val("mem_req.beat_addr", beat_t'(line_beat(a, i)),
                      beat_t'(i_mem_model.wr_addrs[wbase + i]));
            check_val("mem_req.wdata", model_beat(line_beat(a, i)),
                      i_mem_model.wr_data[wbase + i]);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic issue(addr_t a, size_t size, logic is_unsigned, logic is_store, word_t wdata);
        req.addr = a;
        req.size = size;
        req.is_unsigned = is_unsigned;
        req.is_store = is_store;
        req.wdata = wdata;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic do_load(addr_t a, size_t size, logic is_unsigned, logic expect_hit);
        issue(a, size, is_unsigned, 1'b0, '0);
        @(negedge clk);
        // a hit answers in the cycle after acceptance, a miss never does
        check_bit("rsp_valid", expect_hit, rsp_valid);
        while (!rsp_valid) begin
            @(negedge clk);
        end
        check_val("rsp_data", beat_t'(expect_load(a, size, is_unsigned)), beat_t'(rsp_data));
        // one pulse per load
        @(negedge clk);
        check_bit("rsp_valid", 1'b0, rsp_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic do_store(addr_t a, size_t size, word_t wdata);
        issue(a, size, 1'b0, 1'b1, wdata);
        model_store(a, size, wdata);
        @(negedge clk);
        check_bit("rsp_valid", 1'b0, rsp_valid);
        while (!req_ready) begin
            @(negedge clk);
            check_bit("rsp_valid", 1'b0, rsp_valid);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic load_pair(addr_t a0, addr_t a1);
        issue(a0, SIZE_WORD, 1'b0, 1'b0, '0);
        // second load goes out while the first is in lookup
        req.addr = a1;
        req_valid = 1'b1;
        @(negedge clk);
        check_bit("rsp_valid", 1'b1, rsp_valid);
        check_val("rsp_data", beat_t'(expect_load(a0, SIZE_WORD, 1'b0)), beat_t'(rsp_data));
        check_bit("req_ready", 1'b1, req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        check_bit("rsp_valid", 1'b1, rsp_valid);
        check_val("rsp_data", beat_t'(expect_load(a1, SIZE_WORD, 1'b0)), beat_t'(rsp_data));
        @(posedge clk);
        #1;
    endtask

    task automatic sweep_subword(addr_t word_a);
        for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 4; off++) begin
                do_load(word_a + addr_t'(off), SIZE_BYTE, 1'(u), 1'b1);
                if ((off % 2) == 0) begin
                    do_load(word_a + addr_t'(off), SIZE_HALF, 1'(u), 1'b1);
                end
            end
        end
    endtask

    task automatic test_reset();
        @(posedge clk);
        @(negedge clk);
        check_bit("req_ready", 1'b0, req_ready);
        check_bit("mem_req_valid", 1'b0, mem_req_valid);
        @(posedge clk);
        #1;
        rst = 1'b0;
        // first cycle out of reset is still quiet
        @(negedge clk);
        check_bit("req_ready", 1'b0, req_ready);
        check_bit("mem_req_valid", 1'b0, mem_req_valid);
        check_bit("rsp_valid", 1'b0, rsp_valid);
        @(negedge clk);
        check_bit("req_ready", 1'b1, req_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic test_cold_load();
        addr_t a;
        int rbase;
        int wbase;
        a = line_addr(1, 2, 'h14);
        rbase = i_mem_model.rd_count;
        wbase = i_mem_model.wr_count;
        do_load(a, SIZE_WORD, 1'b0, 1'b0);
        check_val("mem read beats", beat_t'(4), beat_t'(i_mem_model.rd_count - rbase));
        for (int i = 0; i < 4; i++) begin
            check_val("mem_req.beat_addr", beat_t'(line_beat(a, i)),
                      beat_t'(i_mem_model.rd_addrs[rbase + i]));
        end
        check_val("mem write beats", beat_t'(0), beat_t'(i_mem_model.wr_count - wbase));
    endtask

    task automatic test_hits();
        do_load(line_addr(1, 2, 'h38), SIZE_WORD, 1'b0, 1'b1);
        load_pair(line_addr(1, 2, 'h00), line_addr(1, 2, 'h24));
    endtask

    task automatic test_subword();
        word_t w;
        // positive low half, negative high half
        w = ($urandom & 32'h7f7f_7f7f) | 32'h8080_0000;
        do_store(line_addr(1, 2, 'h08), SIZE_WORD, w);
        sweep_subword(line_addr(1, 2, 'h08));
        // untouched pattern bytes of this line are all negative
        sweep_subword(line_addr(1, 2, 'h0c));
    endtask

    task automatic test_store_merge();
        addr_t a;
        a = line_addr(2, 3, 'h10);
        do_store(a + addr_t'(1), SIZE_BYTE, $urandom);
        do_store(a + addr_t'(2), SIZE_HALF, $urandom);
        do_load(a, SIZE_WORD, 1'b0, 1'b1);
    endtask

    task automatic test_evict();
        addr_t victim;
        int wbase;
        victim = line_addr(2, 3, 'h00);
        do_store(victim, SIZE_WORD, $urandom);
        do_store(line_addr(2, 3, 'h34), SIZE_WORD, $urandom);
        wbase = i_mem_model.wr_count;
        do_load(line_addr(5, 3, 'h10), SIZE_WORD, 1'b0, 1'b0);
        check_writeback(victim, wbase);
        // the conflicting line came in clean, so its eviction writes nothing
        wbase = i_mem_model.wr_count;
        do_load(line_addr(2, 3, 'h10), SIZE_WORD, 1'b0, 1'b0);
        do_load(victim, SIZE_WORD, 1'b0, 1'b1);
        do_load(line_addr(2, 3, 'h34), SIZE_WORD, 1'b0, 1'b1);
        check_val("mem write beats", beat_t'(0), beat_t'(i_mem_model.wr_count - wbase));
        // set 2 went dirty through a store hit alone
        wbase = i_mem_model.wr_count;
        do_load(line_addr(6, 2, 'h08), SIZE_WORD, 1'b0, 1'b0);
        check_writeback(line_addr(1, 2, 'h00), wbase);
    endtask

    initial begin
        void'($urandom(32'h519921ab));
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[addr_t'(a)] = pattern_byte(addr_t'(a));
        end
        test_reset();
        test_cold_load();
        test_hits();
        test_subword();
        test_store_merge();
        test_evict();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_tags.sv
src/dcache_ctrl.sv
src/dcache_lines.sv
src/dcache_load_align.sv
src/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_dcache_top
FILELIST = sources.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
